//--- clkmgr_defines.svh
`ifndef CLKMGR_DEFINES_SVH
`define CLKMGR_DEFINES_SVH

// register bus
`define CLKMGR_BYTECNT_W 7        // byte counter width on the register bus

// dynamic reconfiguration port
`define CLKMGR_DRP_AW    7        // drp word address width
`define CLKMGR_DRP_DW    16       // drp data width
`define CLKMGR_DIV_ADDR  7'h08    // low byte of this word is the output divider

// phase shift, signed taps -256..255
`define CLKMGR_PHASE_W   9

// behavioural model latencies, in clk_usb cycles
`define CLKMGR_DRP_LAT   4        // den to drdy
`define CLKMGR_PS_LAT    3        // psen to psdone
`define CLKMGR_RELOCK    8        // lock low time after reset or a drp write

`endif

//--- clkmgr_pkg.sv
`default_nettype none
`include "clkmgr_defines.svh"

package clkmgr_pkg;

    // register map of the drp bridge
    typedef enum logic [7:0] {
        REG_DRP_ADDR = 8'h30,     // drp word address
        REG_DRP_DATA = 8'h31,     // write data / read result, byte by bytecnt
        REG_DRP_CTRL = 8'h32      // wr: start, bit0 = write; rd: bit0 = busy
    } reg_addr_e;

    // drp bridge sequencer
    typedef enum logic {
        IDLE,                     // ready for a new transaction
        WAIT_RDY                  // den issued, waiting for drdy
    } drp_state_e;

    // phase shift sequencer
    typedef enum logic [1:0] {
        PS_IDLE,                  // at target, done high
        PS_STEP,                  // compare and issue one step
        PS_WAIT                   // step in flight, waiting for psdone
    } ps_state_e;

    // signed phase in taps
    typedef logic signed [`CLKMGR_PHASE_W-1:0] phase_t;

endpackage

`default_nettype wire

//--- drp_if.sv
`default_nettype none
`include "clkmgr_defines.svh"

// dynamic reconfiguration port, clocked by clk_usb on both sides
interface drp_if;

    logic [`CLKMGR_DRP_AW-1:0] addr;  // word address, valid with den
    logic                      den;   // single cycle transaction strobe
    logic                      dwe;   // qualifies den as a write
    logic [`CLKMGR_DRP_DW-1:0] din;   // write data, valid with den
    logic [`CLKMGR_DRP_DW-1:0] dout;  // read data, valid with drdy
    logic                      drdy;  // single cycle completion pulse

    // bridge side
    modport master (
        output addr, den, dwe, din,
        input  dout, drdy
    );

    // clock manager side
    modport slave (
        input  addr, den, dwe, din,
        output dout, drdy
    );

endinterface

`default_nettype wire

//--- phase_shift_ctrl.sv
`default_nettype none
`include "clkmgr_defines.svh"

module phase_shift_ctrl (
    input  logic                       clk_usb,
    input  logic                       rst_i,
    input  logic [`CLKMGR_PHASE_W-1:0] value_i,     // requested phase, signed taps
    input  logic                       load_i,      // capture value_i when idle
    output logic [`CLKMGR_PHASE_W-1:0] value_o,     // phase actually applied
    output logic                       done_o,      // high while at target
    output logic                       psen_o,      // one step request
    output logic                       psincdec_o,  // 1 = increment
    input  logic                       psdone_i     // step completed by the dcm
);

    clkmgr_pkg::ps_state_e state_q;
    clkmgr_pkg::phase_t    target_q;   // captured request
    clkmgr_pkg::phase_t    value_q;    // current tap position
    clkmgr_pkg::phase_t    value_nxt;  // position after the step in flight

    assign psincdec_o = (target_q > value_q);                  // signed compare
    assign value_nxt  = psincdec_o ? value_q + clkmgr_pkg::phase_t'(1)
                                   : value_q - clkmgr_pkg::phase_t'(1);

    // psen lasts the single PS_STEP cycle, so a tap costs PS_LAT+1 cycles
    assign psen_o  = (state_q == clkmgr_pkg::PS_STEP) && (value_q != target_q);
    assign done_o  = (state_q == clkmgr_pkg::PS_IDLE);
    assign value_o = value_q;

    always_ff @(posedge clk_usb) begin
        if (rst_i) begin
            state_q  <= clkmgr_pkg::PS_IDLE;
            target_q <= '0;
            value_q  <= '0;                                    // dcm starts at zero shift
        end else begin
            case (state_q)
                clkmgr_pkg::PS_IDLE: begin
                    if (load_i) begin                          // loads only taken here
                        target_q <= $signed(value_i);
                        state_q  <= clkmgr_pkg::PS_STEP;
                    end
                end
                clkmgr_pkg::PS_STEP: begin
                    if (value_q == target_q) begin             // request equal to current
                        state_q <= clkmgr_pkg::PS_IDLE;
                    end else begin
                        state_q <= clkmgr_pkg::PS_WAIT;        // psen pulsed this cycle
                    end
                end
                clkmgr_pkg::PS_WAIT: begin
                    if (psdone_i) begin
                        value_q <= value_nxt;                  // one tap per psdone
                        // go straight to idle so done rises with the last tap
                        state_q <= (value_nxt == target_q) ? clkmgr_pkg::PS_IDLE
                                                           : clkmgr_pkg::PS_STEP;
                    end
                end
                default: state_q <= clkmgr_pkg::PS_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- reg_drp_bridge.sv
`default_nettype none
`include "clkmgr_defines.svh"

module reg_drp_bridge (
    input  logic                         clk_usb,
    input  logic                         rst_i,
    input  logic [7:0]                   reg_address_i,
    input  logic [`CLKMGR_BYTECNT_W-1:0] reg_bytecnt_i,
    input  logic [7:0]                   reg_datai_i,
    output logic [7:0]                   reg_datao_o,
    input  logic                         reg_read_i,
    input  logic                         reg_write_i,
    input  logic                         reg_addrvalid_i,
    drp_if.master                        drp
);

    clkmgr_pkg::drp_state_e    state_q;
    logic [`CLKMGR_DRP_AW-1:0] addr_q;    // drp address register
    logic [`CLKMGR_DRP_DW-1:0] wdata_q;   // drp write data, filled a byte at a time
    logic [`CLKMGR_DRP_DW-1:0] rdata_q;   // result of the last drp read
    logic                      den_q;
    logic                      dwe_q;     // direction of the transaction in flight
    logic                      busy;
    logic                      wr_en;

    assign busy  = (state_q == clkmgr_pkg::WAIT_RDY);
    assign wr_en = reg_write_i && reg_addrvalid_i && !busy;   // writes while busy dropped

    assign drp.addr = addr_q;
    assign drp.din  = wdata_q;
    assign drp.den  = den_q;
    assign drp.dwe  = dwe_q;

    // transaction sequencer, one drp access per control write
    always_ff @(posedge clk_usb) begin
        if (rst_i) begin
            state_q <= clkmgr_pkg::IDLE;
            den_q   <= 1'b0;
            dwe_q   <= 1'b0;
        end else begin
            den_q <= 1'b0;                                    // den is a one cycle pulse
            case (state_q)
                clkmgr_pkg::IDLE: begin
                    if (wr_en && reg_address_i == clkmgr_pkg::REG_DRP_CTRL) begin
                        den_q   <= 1'b1;
                        dwe_q   <= reg_datai_i[0];
                        state_q <= clkmgr_pkg::WAIT_RDY;      // busy from here
                    end
                end
                clkmgr_pkg::WAIT_RDY: begin
                    if (drp.drdy) begin
                        state_q <= clkmgr_pkg::IDLE;          // busy drops after drdy
                    end
                end
                default: state_q <= clkmgr_pkg::IDLE;
            endcase
        end
    end

    // address and data registers
    always_ff @(posedge clk_usb) begin
        if (wr_en && reg_address_i == clkmgr_pkg::REG_DRP_ADDR) begin
            addr_q <= reg_datai_i[`CLKMGR_DRP_AW-1:0];
        end
        if (wr_en && reg_address_i == clkmgr_pkg::REG_DRP_DATA) begin
            if (reg_bytecnt_i[0]) begin
                wdata_q[15:8] <= reg_datai_i;                 // high byte
            end else begin
                wdata_q[7:0] <= reg_datai_i;                  // low byte
            end
        end
        if (busy && drp.drdy && !dwe_q) begin
            rdata_q <= drp.dout;                              // dout valid in drdy cycle
        end
    end

    // read back mux
    always_comb begin
        reg_datao_o = 8'h00;
        if (reg_read_i) begin
            case (reg_address_i)
                clkmgr_pkg::REG_DRP_ADDR: reg_datao_o = 8'(addr_q);
                clkmgr_pkg::REG_DRP_DATA: reg_datao_o = reg_bytecnt_i[0] ? rdata_q[15:8]
                                                                          : rdata_q[7:0];
                clkmgr_pkg::REG_DRP_CTRL: reg_datao_o = {7'b0, busy};
                default:                  reg_datao_o = 8'h00;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- clkgen_mmcm_model.sv
`default_nettype none
`include "clkmgr_defines.svh"

module clkgen_mmcm_model (
    input  logic clk_usb,          // drp clock
    input  logic rst_i,
    input  logic clk_in_i,         // reference clock from the clkgen mux
    output logic clk_out_o,        // generated clock
    output logic locked_o,
    drp_if.slave drp
);

    localparam int LAT_W    = $clog2(`CLKMGR_DRP_LAT + 1);
    localparam int RELOCK_W = $clog2(`CLKMGR_RELOCK + 1);
    localparam int WORDS    = 1 << `CLKMGR_DRP_AW;

    logic [`CLKMGR_DRP_DW-1:0] mem [WORDS];   // configuration words
    logic [`CLKMGR_DRP_DW-1:0] dout_q;
    logic                      drdy_q;
    logic [LAT_W-1:0]          lat_cnt;       // cycles left until drdy
    logic                      wr_pend;       // transaction in flight is a write
    logic [RELOCK_W-1:0]       relock_cnt;    // lock stays low while nonzero
    logic [7:0]                div_act;       // divider in use
    logic [7:0]                div_cnt;
    logic                      div_clk;

    assign drp.dout  = dout_q;
    assign drp.drdy  = drdy_q;
    assign locked_o  = (relock_cnt == '0);
    assign clk_out_o = (div_act < 8'd2) ? clk_in_i : div_clk;    // 0 and 1 pass through

    always_ff @(posedge clk_usb) begin
        if (rst_i) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= '0;
            end
            lat_cnt    <= '0;
            drdy_q     <= 1'b0;
            wr_pend    <= 1'b0;
            relock_cnt <= RELOCK_W'(`CLKMGR_RELOCK);    // relock after reset
            div_act    <= 8'd0;
        end else begin
            drdy_q <= !drp.den && (lat_cnt == LAT_W'(1));    // drdy LAT cycles after den
            if (drp.den) begin
                lat_cnt <= LAT_W'(`CLKMGR_DRP_LAT - 1);
                wr_pend <= drp.dwe;
                if (drp.dwe) begin
                    mem[drp.addr] <= drp.din;
                end else begin
                    dout_q <= mem[drp.addr];               // held until drdy
                end
            end else if (lat_cnt != '0) begin
                lat_cnt <= lat_cnt - LAT_W'(1);
            end
            if (drdy_q && wr_pend) begin
                relock_cnt <= RELOCK_W'(`CLKMGR_RELOCK);   // reconfig drops lock
            end else if (relock_cnt != '0) begin
                relock_cnt <= relock_cnt - RELOCK_W'(1);
            end
            if (relock_cnt == RELOCK_W'(1)) begin
                div_act <= mem[`CLKMGR_DIV_ADDR][7:0];    // new divider as lock returns
            end
        end
    end

    // output divider on the reference clock, toggles every div_act edges
    always_ff @(posedge clk_in_i) begin
        if (rst_i || div_act < 8'd2) begin
            div_cnt <= 8'd0;
            div_clk <= 1'b0;
        end else if (div_cnt >= div_act - 8'd1) begin
            div_cnt <= 8'd0;
            div_clk <= ~div_clk;
        end else begin
            div_cnt <= div_cnt + 8'd1;
        end
    end

endmodule

`default_nettype wire

//--- adc_dcm_model.sv
`default_nettype none
`include "clkmgr_defines.svh"

module adc_dcm_model (
    input  logic clk_usb,          // phase shift clock
    input  logic rst_i,
    input  logic psen_i,
    input  logic psincdec_i,
    output logic psdone_o,
    output logic locked_o
);

    localparam int RELOCK_W = $clog2(`CLKMGR_RELOCK + 1);

    logic [`CLKMGR_PS_LAT-1:0]       ps_pipe;     // one bit per step in flight
    logic [RELOCK_W-1:0]             relock_cnt;
    logic signed [`CLKMGR_PHASE_W:0] tap_q;       // one guard bit past the tap range
    logic                            tap_ovf;

    // guard bit differs from sign bit once the shift leaves -256..255
    assign tap_ovf  = tap_q[`CLKMGR_PHASE_W] != tap_q[`CLKMGR_PHASE_W-1];
    assign psdone_o = ps_pipe[`CLKMGR_PS_LAT-1];
    assign locked_o = (relock_cnt == '0) && !tap_ovf;

    always_ff @(posedge clk_usb) begin
        if (rst_i) begin
            ps_pipe    <= '0;
            relock_cnt <= RELOCK_W'(`CLKMGR_RELOCK);
            tap_q      <= '0;
        end else begin
            ps_pipe <= {ps_pipe[`CLKMGR_PS_LAT-2:0], psen_i};    // psdone PS_LAT later
            if (relock_cnt != '0) begin
                relock_cnt <= relock_cnt - RELOCK_W'(1);
            end
            if (psen_i) begin
                tap_q <= psincdec_i ? tap_q + 2'sd1 : tap_q - 2'sd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- clock_mgmt.sv
`default_nettype none
`include "clkmgr_defines.svh"

module clock_mgmt (
    input  logic                         clk_usb,             // system clock
    input  logic                         rst_i,
    input  logic                         clk_ext_i,           // external clock
    input  logic                         adc_clk_feedback_i,  // adc clock back from the board
    input  logic [2:0]                   clkadc_source_i,
    input  logic                         clkgen_source_i,     // 1 = clkgen from clk_ext
    input  logic [`CLKMGR_PHASE_W-1:0]   phase_requested_i,
    input  logic                         phase_load_i,
    output logic [`CLKMGR_PHASE_W-1:0]   phase_actual_o,
    output logic                         phase_done_o,
    output logic                         adc_clk_o,
    output logic                         clkgen_o,
    output logic                         systemsample_clk_o,
    output logic                         dcm_adc_locked_o,
    output logic                         dcm_gen_locked_o,
    input  logic [7:0]                   reg_address_i,
    input  logic [`CLKMGR_BYTECNT_W-1:0] reg_bytecnt_i,
    input  logic [7:0]                   reg_datai_i,
    output logic [7:0]                   reg_datao_o,
    input  logic                         reg_read_i,
    input  logic                         reg_write_i,
    input  logic                         reg_addrvalid_i
);

    logic               clkgen_in;     // reference into the clkgen manager
    logic               clkgen_out;
    logic               dcm_clk_in;    // reference into the adc manager
    logic               psen;
    logic               psincdec;
    logic               psdone;
    clkmgr_pkg::phase_t phase_act;

    drp_if drp_bus ();

    // clock muxes
    assign clkgen_in  = clkgen_source_i ? clk_ext_i : clk_usb;
    assign dcm_clk_in = clkadc_source_i[2] ? clk_ext_i : clkgen_out;
    // adc manager outputs (x1 and x4) both pass dcm_clk_in through, so bit 1 has no effect
    assign adc_clk_o  = clkadc_source_i[0] ? clk_ext_i : dcm_clk_in;
    assign clkgen_o   = clkgen_out;

    assign systemsample_clk_o = adc_clk_feedback_i;    // board compensates adc wire delay
    assign phase_actual_o     = phase_act;

    reg_drp_bridge u_reg_drp_bridge (
        .clk_usb         (clk_usb),
        .rst_i           (rst_i),
        .reg_address_i   (reg_address_i),
        .reg_bytecnt_i   (reg_bytecnt_i),
        .reg_datai_i     (reg_datai_i),
        .reg_datao_o     (reg_datao_o),
        .reg_read_i      (reg_read_i),
        .reg_write_i     (reg_write_i),
        .reg_addrvalid_i (reg_addrvalid_i),
        .drp             (drp_bus.master)
    );

    clkgen_mmcm_model u_clkgen (
        .clk_usb   (clk_usb),
        .rst_i     (rst_i),
        .clk_in_i  (clkgen_in),
        .clk_out_o (clkgen_out),
        .locked_o  (dcm_gen_locked_o),
        .drp       (drp_bus.slave)
    );

    phase_shift_ctrl u_phase_shift_ctrl (
        .clk_usb    (clk_usb),
        .rst_i      (rst_i),
        .value_i    (phase_requested_i),
        .load_i     (phase_load_i),
        .value_o    (phase_act),
        .done_o     (phase_done_o),
        .psen_o     (psen),
        .psincdec_o (psincdec),
        .psdone_i   (psdone)
    );

    adc_dcm_model u_adc_dcm (
        .clk_usb    (clk_usb),
        .rst_i      (rst_i),
        .psen_i     (psen),
        .psincdec_i (psincdec),
        .psdone_o   (psdone),
        .locked_o   (dcm_adc_locked_o)
    );

endmodule

`default_nettype wire

//--- clock_mgmt_asserts.sv
`default_nettype none
`include "clkmgr_defines.svh"

// handshake checks on the drp bridge and the phase shift controller
module clock_mgmt_asserts (
    input logic                       clk_i,
    input logic                       rst_i,
    input logic                       den_i,
    input logic                       drdy_i,
    input logic                       psen_i,
    input logic                       psdone_i,
    input logic [`CLKMGR_PHASE_W-1:0] value_i     // phase_shift_ctrl value_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_cnt = 0;                    // assertion failures so far

    a_den_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
        den_i |=> !den_i [*`CLKMGR_DRP_LAT])      // no den until drdy has pulsed
        else begin
            fail_cnt++;
            $error("den issued while a drp transaction was open");
        end

    a_drdy_latency: assert property (@(posedge clk_i) disable iff (rst_i)
        den_i |-> ##`CLKMGR_DRP_LAT drdy_i)
        else begin
            fail_cnt++;
            $error("drdy did not follow den after the drp latency");
        end

    a_psen_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        psen_i |=> !psen_i)                       // one cycle step request
        else begin
            fail_cnt++;
            $error("psen held for more than one cycle");
        end

    a_value_after_psdone: assert property (@(posedge clk_i) disable iff (rst_i)
        !$stable(value_i) |-> $past(psdone_i))
        else begin
            fail_cnt++;
            $error("phase value moved without a psdone");
        end

endmodule

bind clock_mgmt clock_mgmt_asserts u_asserts (
    .clk_i    (clk_usb),
    .rst_i    (rst_i),
    .den_i    (drp_bus.den),
    .drdy_i   (drp_bus.drdy),
    .psen_i   (psen),
    .psdone_i (psdone),
    .value_i  (phase_act)
);

`default_nettype wire

//--- clock_mgmt_tb.sv
`default_nettype none
`include "clkmgr_defines.svh"

module clock_mgmt_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int USB_PERIOD     = 40;
    localparam int EXT_PERIOD     = 28;
    localparam int WALK_CYCLES    = 6 * 511 * (`CLKMGR_PS_LAT + 1);  // six worst case walks
    localparam int TIMEOUT_CYCLES = (WALK_CYCLES + 2000) * 3 / 2;    // other tests ~2000 cycles

    logic                         clk_usb = 1'b0;
    logic                         clk_ext = 1'b0;
    logic                         rst = 1'b1;
    logic                         adc_fb = 1'b0;       // adc clock feedback from the board
    logic [2:0]                   clkadc_source = '0;
    logic                         clkgen_source = 1'b0;
    logic [`CLKMGR_PHASE_W-1:0]   phase_requested = '0;
    logic                         phase_load = 1'b0;
    logic [7:0]                   reg_address = '0;
    logic [`CLKMGR_BYTECNT_W-1:0] reg_bytecnt = '0;
    logic [7:0]                   reg_datai = '0;
    logic                         reg_read = 1'b0;
    logic                         reg_write = 1'b0;
    logic                         reg_addrvalid = 1'b0;
    logic [`CLKMGR_PHASE_W-1:0]   phase_actual;
    logic                         phase_done;
    logic                         adc_clk;
    logic                         clkgen;
    logic                         sample_clk;
    logic                         dcm_adc_locked;
    logic                         dcm_gen_locked;
    logic [7:0]                   reg_datao;
    logic [15:0]                  drp_mem [128];       // expected drp contents
    int                           got_q[$];
    int                           want_q[$];
    string                        what_q[$];
    int                           errors = 0;
    int                           checks = 0;

    clock_mgmt u_dut (
        .clk_usb (clk_usb), .rst_i (rst), .clk_ext_i (clk_ext), .adc_clk_feedback_i (adc_fb),
        .clkadc_source_i (clkadc_source), .clkgen_source_i (clkgen_source),
        .phase_requested_i (phase_requested), .phase_load_i (phase_load),
        .phase_actual_o (phase_actual), .phase_done_o (phase_done), .adc_clk_o (adc_clk),
        .clkgen_o (clkgen), .systemsample_clk_o (sample_clk),
        .dcm_adc_locked_o (dcm_adc_locked), .dcm_gen_locked_o (dcm_gen_locked),
        .reg_address_i (reg_address), .reg_bytecnt_i (reg_bytecnt), .reg_datai_i (reg_datai),
        .reg_datao_o (reg_datao), .reg_read_i (reg_read), .reg_write_i (reg_write),
        .reg_addrvalid_i (reg_addrvalid)
    );

    always #(USB_PERIOD / 2) clk_usb = ~clk_usb;
    always #(EXT_PERIOD / 2) clk_ext = ~clk_ext;
    always @(posedge clk_usb) adc_fb <= #2 ~adc_fb;      // feedback toggles every cycle

    function automatic int exp_phase(input logic [`CLKMGR_PHASE_W-1:0] req);
        return int'($signed(req));                       // walk settles exactly on the request
    endfunction

    function automatic int exp_div_period(input int div, input int in_period);
        return (div < 2) ? in_period : 2 * div * in_period;   // toggles every div input edges
    endfunction

    function automatic logic exp_adc_src(input logic [2:0] src, input logic ext, input logic gen);
        return (src[0] || src[2]) ? ext : gen;           // bit 1 picks between equal outputs
    endfunction

    task automatic check_later(input int got, input int want, input string what);
        got_q.push_back(got);
        want_q.push_back(want);
        what_q.push_back(what);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    task automatic finish_run();
        int total;
        total = errors + int'(u_dut.u_asserts.fail_cnt);
        $display("checks: %0d, errors: %0d", checks, total);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    always @(posedge clk_usb) begin : compare
        int got;
        int want;
        string what;
        while (got_q.size() > 0) begin
            got  = got_q.pop_front();
            want = want_q.pop_front();
            what = what_q.pop_front();
            checks++;
            assert (got == want) else begin
                errors++;
                $display("mismatch at %0t ns: %s got %0d expected %0d", $time, what, got, want);
            end
        end
    end

    task automatic bus_write(input logic [7:0] addr, input logic [7:0] data, input int bc);
        reg_address   = addr;
        reg_datai     = data;
        reg_bytecnt   = `CLKMGR_BYTECNT_W'(bc);
        reg_write     = 1'b1;
        reg_addrvalid = 1'b1;
        @(posedge clk_usb);
        #2;
        reg_write     = 1'b0;
        reg_addrvalid = 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] addr, input int bc, output logic [7:0] data);
        reg_address = addr;
        reg_bytecnt = `CLKMGR_BYTECNT_W'(bc);
        reg_read    = 1'b1;
        @(negedge clk_usb);
        data = reg_datao;                                // combinational and settled by mid cycle
        @(posedge clk_usb);
        #2;
        reg_read = 1'b0;
    endtask

    task automatic wait_drp_idle();
        logic [7:0] ctrl;
        int tries;
        ctrl  = 8'h01;
        tries = 0;
        while (ctrl[0] && tries < 4 * `CLKMGR_DRP_LAT) begin
            bus_read(clkmgr_pkg::REG_DRP_CTRL, 0, ctrl);     // poll busy
            tries++;
        end
        if (ctrl[0]) report_failure("drp bridge stayed busy");
    endtask

    task automatic read_data(output logic [15:0] data);
        bus_read(clkmgr_pkg::REG_DRP_DATA, 0, data[7:0]);
        bus_read(clkmgr_pkg::REG_DRP_DATA, 1, data[15:8]);
    endtask

    task automatic drp_write(input int addr, input logic [15:0] data);
        bus_write(clkmgr_pkg::REG_DRP_ADDR, 8'(addr), 0);
        bus_write(clkmgr_pkg::REG_DRP_DATA, data[7:0], 0);
        bus_write(clkmgr_pkg::REG_DRP_DATA, data[15:8], 1);
        bus_write(clkmgr_pkg::REG_DRP_CTRL, 8'h01, 0);      // bit0 set for a write
        wait_drp_idle();
        drp_mem[addr] = data;
    endtask

    task automatic drp_read(input int addr, output logic [15:0] data);
        bus_write(clkmgr_pkg::REG_DRP_ADDR, 8'(addr), 0);
        bus_write(clkmgr_pkg::REG_DRP_CTRL, 8'h00, 0);
        wait_drp_idle();
        read_data(data);
    endtask

    task automatic phase_walk(input logic [`CLKMGR_PHASE_W-1:0] target);
        int prev;
        int cur;
        int dir;
        int n;
        prev = int'($signed(phase_actual));
        cur  = prev;
        dir  = (exp_phase(target) > prev) ? 1 : -1;
        phase_requested = target;
        phase_load      = 1'b1;
        @(posedge clk_usb);
        #2;
        phase_load = 1'b0;
        @(negedge clk_usb);
        check_later(int'(phase_done), 0, "phase done after load");
        n = 0;
        while (!phase_done && n < 512 * (`CLKMGR_PS_LAT + 1) + 8) begin
            @(negedge clk_usb);
            cur = int'($signed(phase_actual));
            check_later(int'(cur == prev || cur == prev + dir), 1, "phase moves one tap");
            prev = cur;
            n++;
        end
        if (!phase_done) report_failure("phase walk never reached its target");
        check_later(cur, exp_phase(target), "final phase");
        check_later(int'(dcm_adc_locked), 1, "adc lock after phase walk");
        @(posedge clk_usb);
        #2;
    endtask

    task automatic measure_div(input int div);
        time t0;
        int n;
        int src;
        drp_write(`CLKMGR_DIV_ADDR, 16'(div));
        check_later(int'(dcm_gen_locked), 0, "clkgen lock during reconfiguration");
        n = 0;
        while (!dcm_gen_locked && n < `CLKMGR_RELOCK + 4) begin
            @(negedge clk_usb);
            n++;
        end
        if (!dcm_gen_locked) report_failure("clkgen lock did not return after a divider write");
        for (src = 0; src < 2; src++) begin
            @(posedge clk_usb);
            #2;
            clkgen_source = src[0];
            repeat (3) @(posedge clkgen);                // let the divider settle on the new source
            t0 = $time;
            @(posedge clkgen);
            check_later(int'($time - t0), exp_div_period(div, src ? EXT_PERIOD : USB_PERIOD),
                        "clkgen period");
        end
        @(posedge clk_usb);
        #2;
        clkgen_source = 1'b0;
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_usb);
            cycles++;
        end
        report_failure($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        finish_run();
    end

    initial begin : stimulus
        logic [15:0] rd;
        logic [15:0] v;
        int addr_list[20];
        int a;
        int b;
        int i;
        void'($urandom(32'hbb9c));
        foreach (drp_mem[k]) drp_mem[k] = '0;            // model words reset to zero
        repeat (2) @(posedge clk_usb);
        #2;
        rst = 1'b0;
        // state right after reset
        check_later(int'(phase_done), 1, "phase done after reset");
        check_later(int'($signed(phase_actual)), 0, "phase after reset");
        check_later(int'(dcm_gen_locked || dcm_adc_locked), 0, "locks after reset");
        i = 0;
        while (!(dcm_gen_locked && dcm_adc_locked) && i < `CLKMGR_RELOCK + 2) begin
            @(negedge clk_usb);
            i++;
        end
        if (!(dcm_gen_locked && dcm_adc_locked)) report_failure("locks did not rise after reset");
        @(posedge clk_usb);
        #2;
        // drp round trip
        for (i = 0; i < 20; i++) begin
            addr_list[i] = $urandom_range(127, 0);
            drp_write(addr_list[i], 16'($urandom));
        end
        for (i = 0; i < 20; i++) begin
            drp_read(addr_list[i], rd);
            check_later(int'(rd[7:0]), int'(drp_mem[addr_list[i]][7:0]), "drp low byte");
            check_later(int'(rd[15:8]), int'(drp_mem[addr_list[i]][15:8]), "drp high byte");
        end
        // busy timing then a control write dropped while busy
        a = addr_list[0];
        b = a ^ 1;
        bus_write(clkmgr_pkg::REG_DRP_ADDR, 8'(a), 0);
        bus_write(clkmgr_pkg::REG_DRP_CTRL, 8'h00, 0);
        reg_address = clkmgr_pkg::REG_DRP_CTRL;
        reg_read    = 1'b1;
        for (i = 1; i <= `CLKMGR_DRP_LAT + 2; i++) begin
            @(negedge clk_usb);
            check_later(int'(reg_datao[0]), int'(i <= `CLKMGR_DRP_LAT + 1), "busy after ctrl write");
            @(posedge clk_usb);
            #2;
        end
        reg_read = 1'b0;
        read_data(rd);
        check_later(int'(rd), int'(drp_mem[a]), "read data before busy write");
        v = ~drp_mem[a];
        bus_write(clkmgr_pkg::REG_DRP_ADDR, 8'(b), 0);
        bus_write(clkmgr_pkg::REG_DRP_DATA, v[7:0], 0);
        bus_write(clkmgr_pkg::REG_DRP_DATA, v[15:8], 1);
        bus_write(clkmgr_pkg::REG_DRP_CTRL, 8'h01, 0);
        bus_write(clkmgr_pkg::REG_DRP_CTRL, 8'h00, 0);   // lands while busy
        wait_drp_idle();
        drp_mem[b] = v;
        read_data(rd);
        check_later(int'(rd), int'(drp_mem[a]), "read data after write while busy");
        // phase walks with the extremes in slots 1 and 2
        for (i = 0; i < 6; i++) begin
            phase_walk((i == 1) ? 9'h100 : (i == 2) ? 9'h0ff : 9'($urandom));
        end
        measure_div(2);
        measure_div(5);
        measure_div(1);                                  // leaves clkgen in pass-through
        // clock muxes sampled 1 ns after every edge of either clock
        for (i = 0; i < 16; i++) begin
            clkadc_source = i[2:0];
            clkgen_source = i[3];
            repeat (12) begin
                @(clk_ext or clk_usb);
                #1;
                check_later(int'(adc_clk), int'(exp_adc_src(clkadc_source, clk_ext,
                            clkgen_source ? clk_ext : clk_usb)), "adc clock source");
                check_later(int'(sample_clk), int'(adc_fb), "systemsample clock");
            end
            @(posedge clk_usb);
            #2;
        end
        repeat (2) @(posedge clk_usb);                   // drain the compare queue
        finish_run();
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
clkmgr_pkg.sv
drp_if.sv
phase_shift_ctrl.sv
reg_drp_bridge.sv
clkgen_mmcm_model.sv
adc_dcm_model.sv
clock_mgmt.sv
clock_mgmt_asserts.sv
clock_mgmt_tb.sv
